// File: hw/cache_pkg.sv
//////////////////////////////
// Shared sizes, enums and structs for the data cache
// Imported by every cache module and by the checker
//////////////////////////////

package cache_pkg;

    // Geometry
    localparam int ADDR_W  = 16;
    localparam int DATA_W  = 32;
    localparam int WAYS    = 4;
    localparam int SETS    = 16;
    localparam int WAY_W   = $clog2(WAYS);
    localparam int INDEX_W = $clog2(SETS);
    localparam int TAG_W   = ADDR_W - INDEX_W;
    localparam int PLRU_W  = WAYS - 1;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_t;

    // Memory side sequencing
    typedef enum logic [2:0] {
        MS_IDLE,
        MS_WB,
        MS_WB_WAIT,
        MS_FILL,
        MS_FILL_WAIT
    } mem_state_t;

    typedef struct packed {
        cache_op_t           op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } cache_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                hit;
    } cache_resp_t;

    // Victim data rides along so the memory stage needs no array access
    typedef struct packed {
        logic [ADDR_W-1:0]   fill_addr;
        logic                wb;
        logic [ADDR_W-1:0]   wb_addr;
        logic [DATA_W-1:0]   wb_data;
    } miss_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } mem_wr_t;

endpackage

// File: hw/cache_lookup_stage.sv
//////////////////////////////
// Lookup stage of the cache: captures a request, checks all ways,
// answers hits and hands misses to the memory stage
//////////////////////////////

module cache_lookup_stage
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  cache_req_t          req,
    output logic                busy,
    output logic                resp_valid,
    output cache_resp_t         resp,
    output logic                miss_start,
    output miss_req_t           miss,
    input  logic                fill_valid,
    input  logic [DATA_W-1:0]   fill_data,
    output logic [31:0]         hit_count,
    output logic [31:0]         miss_count,
    output logic [31:0]         eviction_count
);

    // Tree step: root bit takes the half, leaf bit the way within it
    function automatic logic [PLRU_W-1:0] plru_touch(logic [PLRU_W-1:0] bits,
                                                     logic [WAY_W-1:0] way);
        logic [PLRU_W-1:0] nxt;
        nxt    = bits;
        nxt[0] = way[1];
        if (way[1]) begin
            nxt[2] = way[0];
        end else begin
            nxt[1] = way[0];
        end
        return nxt;
    endfunction

    function automatic logic [WAY_W-1:0] plru_victim(logic [PLRU_W-1:0] bits);
        logic [WAY_W-1:0] way;
        way[1] = ~bits[0];
        way[0] = way[1] ? ~bits[2] : ~bits[1];
        return way;
    endfunction

    logic [TAG_W-1:0]   tag_arr   [SETS][WAYS];
    logic [DATA_W-1:0]  data_arr  [SETS][WAYS];
    logic [WAYS-1:0]    valid_arr [SETS];
    logic [WAYS-1:0]    dirty_arr [SETS];
    logic [PLRU_W-1:0]  plru_arr  [SETS];

    cache_req_t          req_q;
    logic                lookup_q;
    logic                wait_fill;
    logic [WAY_W-1:0]    victim_q;

    logic                accept;
    logic [TAG_W-1:0]    lk_tag;
    logic [INDEX_W-1:0]  lk_index;
    logic                hit;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    victim;
    logic                wb_needed;
    logic                is_write;
    logic                do_fill;

    assign accept              = req_valid && !busy;
    assign {lk_tag, lk_index}  = req_q.addr;
    assign is_write            = (req_q.op == OP_WRITE);
    assign do_fill             = wait_fill && fill_valid;
    assign victim              = plru_victim(plru_arr[lk_index]);
    assign wb_needed           = valid_arr[lk_index][victim] && dirty_arr[lk_index][victim];

    // Tag compare across the set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_arr[lk_index][w] && tag_arr[lk_index][w] == lk_tag) begin
                hit     = 1'b1;
                hit_way = w[WAY_W-1:0];
            end
        end
    end

    // Request and response control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            lookup_q   <= 1'b0;
            wait_fill  <= 1'b0;
            resp_valid <= 1'b0;
            miss_start <= 1'b0;
        end else begin
            resp_valid <= 1'b0;
            miss_start <= 1'b0;
            lookup_q   <= accept;
            if (accept) begin
                busy <= 1'b1;
            end
            if (lookup_q && hit) begin
                resp_valid <= 1'b1;
                busy       <= 1'b0;
            end else if (lookup_q) begin
                miss_start <= 1'b1;
                wait_fill  <= 1'b1;
            end
            if (do_fill) begin
                wait_fill  <= 1'b0;
                resp_valid <= 1'b1;
                busy       <= 1'b0;
            end
        end
    end

    // Captured request and outgoing payloads
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
        if (lookup_q && hit) begin
            resp.rdata <= is_write ? req_q.wdata : data_arr[lk_index][hit_way];
            resp.hit   <= 1'b1;
        end else if (lookup_q) begin
            victim_q       <= victim;
            miss.fill_addr <= req_q.addr;
            miss.wb        <= wb_needed;
            miss.wb_addr   <= {tag_arr[lk_index][victim], lk_index};
            miss.wb_data   <= data_arr[lk_index][victim];
        end
        if (do_fill) begin
            resp.rdata <= is_write ? req_q.wdata : fill_data;
            resp.hit   <= 1'b0;
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (lookup_q && hit && is_write) begin
            data_arr[lk_index][hit_way] <= req_q.wdata;
        end
        if (do_fill) begin
            tag_arr[lk_index][victim_q]  <= lk_tag;
            // Write miss data replaces the whole one-word line
            data_arr[lk_index][victim_q] <= is_write ? req_q.wdata : fill_data;
        end
    end

    // Line state, tree bits and counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr      <= '{default: '0};
            dirty_arr      <= '{default: '0};
            plru_arr       <= '{default: '0};
            hit_count      <= '0;
            miss_count     <= '0;
            eviction_count <= '0;
        end else begin
            if (lookup_q && hit) begin
                hit_count          <= hit_count + 32'd1;
                plru_arr[lk_index] <= plru_touch(plru_arr[lk_index], hit_way);
                if (is_write) begin
                    dirty_arr[lk_index][hit_way] <= 1'b1;
                end
            end else if (lookup_q) begin
                miss_count <= miss_count + 32'd1;
                if (wb_needed) begin
                    eviction_count <= eviction_count + 32'd1;
                end
            end
            if (do_fill) begin
                valid_arr[lk_index][victim_q] <= 1'b1;
                dirty_arr[lk_index][victim_q] <= is_write;
                plru_arr[lk_index]            <= plru_touch(plru_arr[lk_index], victim_q);
            end
        end
    end

endmodule

// File: hw/cache_mem_stage.sv
//////////////////////////////
// Memory stage of the cache: write-back of a dirty victim,
// then the refill read, returned to the lookup stage
//////////////////////////////

module cache_mem_stage
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                miss_start,
    input  miss_req_t           miss,
    output logic                fill_valid,
    output logic [DATA_W-1:0]   fill_data,
    output logic                mem_wr_req,
    output mem_wr_t             mem_wr,
    input  logic                mem_wr_ack,
    output logic                mem_rd_req,
    output logic [ADDR_W-1:0]   mem_rd_addr,
    input  logic                mem_rd_valid,
    input  logic [DATA_W-1:0]   mem_rd_data
);

    mem_state_t  state;
    miss_req_t   miss_q;

    // Request pulses come straight from the state
    assign mem_wr_req  = (state == MS_WB);
    assign mem_rd_req  = (state == MS_FILL);
    assign mem_wr.addr = miss_q.wb_addr;
    assign mem_wr.data = miss_q.wb_data;
    assign mem_rd_addr = miss_q.fill_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= MS_IDLE;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                MS_IDLE: begin
                    if (miss_start) begin
                        state <= miss.wb ? MS_WB : MS_FILL;
                    end
                end
                MS_WB: begin
                    state <= mem_wr_ack ? MS_FILL : MS_WB_WAIT;
                end
                MS_WB_WAIT: begin
                    // Refill read held back until the write-back is acknowledged
                    if (mem_wr_ack) begin
                        state <= MS_FILL;
                    end
                end
                MS_FILL, MS_FILL_WAIT: begin
                    if (mem_rd_valid) begin
                        state      <= MS_IDLE;
                        fill_valid <= 1'b1;
                    end else begin
                        state <= MS_FILL_WAIT;
                    end
                end
                default: begin
                    state <= MS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == MS_IDLE && miss_start) begin
            miss_q <= miss;
        end
        if (mem_rd_valid) begin
            fill_data <= mem_rd_data;
        end
    end

endmodule

// File: hw/cache_top.sv
//////////////////////////////
// Cache top level, lookup stage feeding the memory stage
//////////////////////////////

module cache_top
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  cache_req_t          req,
    output logic                busy,
    output logic                resp_valid,
    output cache_resp_t         resp,
    output logic                mem_wr_req,
    output mem_wr_t             mem_wr,
    input  logic                mem_wr_ack,
    output logic                mem_rd_req,
    output logic [ADDR_W-1:0]   mem_rd_addr,
    input  logic                mem_rd_valid,
    input  logic [DATA_W-1:0]   mem_rd_data,
    output logic [31:0]         hit_count,
    output logic [31:0]         miss_count,
    output logic [31:0]         eviction_count
);

    logic               miss_start;
    miss_req_t          miss;
    logic               fill_valid;
    logic [DATA_W-1:0]  fill_data;

    cache_lookup_stage u_lookup (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid      (req_valid),
        .req            (req),
        .busy           (busy),
        .resp_valid     (resp_valid),
        .resp           (resp),
        .miss_start     (miss_start),
        .miss           (miss),
        .fill_valid     (fill_valid),
        .fill_data      (fill_data),
        .hit_count      (hit_count),
        .miss_count     (miss_count),
        .eviction_count (eviction_count)
    );

    cache_mem_stage u_mem (
        .clk          (clk),
        .rst_n        (rst_n),
        .miss_start   (miss_start),
        .miss         (miss),
        .fill_valid   (fill_valid),
        .fill_data    (fill_data),
        .mem_wr_req   (mem_wr_req),
        .mem_wr       (mem_wr),
        .mem_wr_ack   (mem_wr_ack),
        .mem_rd_req   (mem_rd_req),
        .mem_rd_addr  (mem_rd_addr),
        .mem_rd_valid (mem_rd_valid),
        .mem_rd_data  (mem_rd_data)
    );

endmodule

// File: bench/cache_props.sv
//////////////////////////////
// Handshake assertions, bound into the cache lookup stage
//////////////////////////////

module cache_props (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic busy,
    input logic resp_valid,
    input logic miss_start
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read back by the testbench at the end of the run
    int assert_failures = 0;

    // A response needs a request in progress or just accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(busy || req_valid))
    else begin
        assert_failures++;
        $error("resp_valid without a request in progress");
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(miss_start && resp_valid))
    else begin
        assert_failures++;
        $error("miss_start and resp_valid in the same cycle");
    end

    assert property (@(posedge clk) disable iff (!rst_n) $fell(busy) |-> resp_valid)
    else begin
        assert_failures++;
        $error("busy fell without resp_valid");
    end

endmodule

// File: bench/cache_checker.sv
//////////////////////////////
// Watches the cache ports, keeps a shadow memory and
// compares responses, write-backs and counters
//////////////////////////////

module cache_checker
    import cache_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  cache_req_t          req,
    input  logic                busy,
    input  logic                resp_valid,
    input  cache_resp_t         resp,
    input  logic                mem_wr_req,
    input  mem_wr_t             mem_wr,
    input  logic                mem_wr_ack,
    input  logic                mem_rd_req,
    input  logic [ADDR_W-1:0]   mem_rd_addr,
    input  logic [31:0]         hit_count,
    input  logic [31:0]         miss_count,
    input  logic [31:0]         eviction_count,
    input  logic [DATA_W-1:0]   exp_rdata,
    input  logic                exp_hit,
    input  logic                done,
    output logic                finished,
    output int                  error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Only written addresses are stored
    logic [DATA_W-1:0]  shadow [logic [ADDR_W-1:0]];
    cache_req_t         cur_req;
    logic [DATA_W-1:0]  cur_exp_rdata;
    logic               cur_exp_hit;
    logic               wb_pending;
    int test_num;
    int test_errors;
    int tests_failed;
    int exp_hits;
    int exp_misses;
    int wr_pulses;

    function automatic logic [DATA_W-1:0] shadow_word(logic [ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return 32'h5a5a0000 ^ DATA_W'(addr);
    endfunction

    task automatic compare_value(string name, logic [31:0] exp_val, logic [31:0] act_val);
        if (exp_val !== act_val) begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp_val, act_val);
            error_count++;
            test_errors++;
        end
    endtask

    always @(posedge clk) begin
        if (!rst_n) begin
            error_count  = 0;
            test_num     = 0;
            test_errors  = 0;
            tests_failed = 0;
            exp_hits     = 0;
            exp_misses   = 0;
            wr_pulses    = 0;
            wb_pending   = 1'b0;
            finished     = 1'b0;
        end else begin
            if (resp_valid) begin
                compare_value("resp.rdata", shadow_word(cur_req.addr), resp.rdata);
                compare_value("resp.rdata vs file", cur_exp_rdata, resp.rdata);
                compare_value("resp.hit", 32'(cur_exp_hit), 32'(resp.hit));
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("Test %0d %s addr %h hit %0d: %s", test_num,
                         cur_req.op == OP_WRITE ? "write" : "read", cur_req.addr,
                         resp.hit, test_errors == 0 ? "ok" : "FAILED");
            end
            if (req_valid && !busy) begin
                cur_req       = req;
                cur_exp_rdata = exp_rdata;
                cur_exp_hit   = exp_hit;
                test_errors   = 0;
                test_num++;
                if (exp_hit) begin
                    exp_hits++;
                end else begin
                    exp_misses++;
                end
                if (req.op == OP_WRITE) begin
                    shadow[req.addr] = req.wdata;
                end
            end
            // Write-back bookkeeping and ordering
            if (mem_wr_ack) begin
                wb_pending = 1'b0;
            end
            if (mem_wr_req) begin
                wr_pulses++;
                wb_pending = 1'b1;
                if (!shadow.exists(mem_wr.addr)) begin
                    $display("Write-back at %0t ns of address %h, which was never written",
                             $time, mem_wr.addr);
                    error_count++;
                    test_errors++;
                end else begin
                    compare_value("mem_wr.data", shadow[mem_wr.addr], mem_wr.data);
                end
            end
            if (mem_rd_req) begin
                // Refill fetches the word that missed
                compare_value("mem_rd_addr", 32'(cur_req.addr), 32'(mem_rd_addr));
                if (wb_pending) begin
                    $display("Refill read at %0t ns issued before its write-back was acknowledged",
                             $time);
                    error_count++;
                    test_errors++;
                end
            end
            if (done && !finished) begin
                compare_value("hit_count", 32'(exp_hits), hit_count);
                compare_value("miss_count", 32'(exp_misses), miss_count);
                compare_value("eviction_count", 32'(wr_pulses), eviction_count);
                $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
                         test_num, test_num - tests_failed, tests_failed, error_count);
                finished = 1'b1;
            end
        end
    end

endmodule

// File: bench/cache_tb.sv
//////////////////////////////
// Testbench for the cache: runs the request file against
// a memory model with random latency
//////////////////////////////

module cache_tb
    import cache_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VECS = 64;

    logic clk;
    logic rst_n;
    logic req_valid;
    cache_req_t req;
    logic busy;
    logic resp_valid;
    cache_resp_t resp;
    logic mem_wr_req;
    mem_wr_t mem_wr;
    logic mem_wr_ack;
    logic mem_rd_req;
    logic [ADDR_W-1:0] mem_rd_addr;
    logic mem_rd_valid;
    logic [DATA_W-1:0] mem_rd_data;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic [31:0] eviction_count;
    logic [DATA_W-1:0] exp_rdata;
    logic exp_hit;
    logic done;
    logic finished;
    int chk_errors;

    // Five hex words per request
    logic [31:0] vec_words [0:5*MAX_VECS-1];
    logic [DATA_W-1:0] mem_model [0:2**ADDR_W-1];
    int num_vecs;
    logic vecs_loaded = 1'b0;
    logic [31:0] lfsr_state = 32'ha8651420;

    cache_top dut (.*);

    cache_checker u_checker (.*, .error_count(chk_errors));

    bind cache_lookup_stage cache_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .busy       (busy),
        .resp_valid (resp_valid),
        .miss_start (miss_start)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic pick_delay(output int cycles);
        logic [1:0] bits;
        lfsr_state = lfsr_next(lfsr_state);
        bits[0] = lfsr_state[0];
        lfsr_state = lfsr_next(lfsr_state);
        bits[1] = lfsr_state[0];
        cycles = int'(bits) + 1;
    endtask

    task automatic load_vectors();
        // Unused entries stay all ones and match no op
        for (int i = 0; i < 5 * MAX_VECS; i++) begin
            vec_words[i] = '1;
        end
        $readmemh("bench/cache_input.txt", vec_words);
        num_vecs = 0;
        while (num_vecs < MAX_VECS && vec_words[5 * num_vecs] <= 32'd1) begin
            num_vecs++;
        end
        for (int a = 0; a < 2**ADDR_W; a++) begin
            mem_model[a] = 32'h5a5a0000 ^ 32'(a);
        end
        vecs_loaded = 1'b1;
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Memory model, one transaction at a time
    initial begin
        int cycles;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        wait (rst_n === 1'b1);
        forever begin
            @(posedge clk);
            if (mem_wr_req) begin
                addr = mem_wr.addr;
                data = mem_wr.data;
                pick_delay(cycles);
                repeat (cycles - 1) @(posedge clk);
                mem_model[addr] = data;
                mem_wr_ack <= 1'b1;
                @(posedge clk);
                mem_wr_ack <= 1'b0;
            end else if (mem_rd_req) begin
                addr = mem_rd_addr;
                pick_delay(cycles);
                repeat (cycles - 1) @(posedge clk);
                mem_rd_valid <= 1'b1;
                mem_rd_data  <= mem_model[addr];
                @(posedge clk);
                mem_rd_valid <= 1'b0;
            end
        end
    end

    initial begin
        wait (vecs_loaded);
        repeat (num_vecs * 40 + 200) @(posedge clk);
        $display("Timeout: requests still outstanding after %0d clock periods",
                 num_vecs * 40 + 200);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        req_valid    = 1'b0;
        req          = '0;
        mem_wr_ack   = 1'b0;
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
        exp_rdata    = '0;
        exp_hit      = 1'b0;
        done         = 1'b0;
        load_vectors();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int i = 0; i < num_vecs; i++) begin
            while (busy) @(posedge clk);
            req_valid <= 1'b1;
            req.op    <= cache_op_t'(vec_words[5*i][0]);
            req.addr  <= vec_words[5*i+1][ADDR_W-1:0];
            req.wdata <= vec_words[5*i+2];
            exp_rdata <= vec_words[5*i+3];
            exp_hit   <= vec_words[5*i+4][0];
            @(posedge clk);
            req_valid <= 1'b0;
            @(posedge clk);
            while (!resp_valid) @(posedge clk);
        end
        done <= 1'b1;
        wait (finished);
        if (num_vecs > 0 && chk_errors == 0 && dut.u_lookup.u_props.assert_failures == 0) begin
            $display("TEST PASS");
        end else begin
            if (num_vecs == 0) begin
                $display("No requests were read from the input file");
            end
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: files.f
hw/cache_pkg.sv
hw/cache_lookup_stage.sv
hw/cache_mem_stage.sv
hw/cache_top.sv
bench/cache_props.sv
bench/cache_checker.sv
bench/cache_tb.sv

// File: Bender.yml
package:
  name: cache

sources:
  - hw/cache_pkg.sv
  - hw/cache_lookup_stage.sv
  - hw/cache_mem_stage.sv
  - hw/cache_top.sv
  - target: test
    files:
      - bench/cache_props.sv
      - bench/cache_checker.sv
      - bench/cache_tb.sv

// File: bench/cache_input.txt
// Hex columns are op (0 read or 1 write), addr, wdata, expected rdata and expected hit
// Set 3 sees more than four tags so the predicted victims get evicted
0 0013 00000000 5a5a0013 0
1 0023 11110023 11110023 0
0 0033 00000000 5a5a0033 0
1 0043 22220043 22220043 0
0 0023 00000000 11110023 1
0 0053 00000000 5a5a0053 0
0 0013 00000000 5a5a0013 0
0 0043 00000000 22220043 0
1 0053 33330053 33330053 1
0 0033 00000000 5a5a0033 0
0 0023 00000000 11110023 0
0 0053 00000000 33330053 1
0 0013 00000000 5a5a0013 1
1 0105 44440105 44440105 0
0 0105 00000000 44440105 1
0 0107 00000000 5a5a0107 0
0 0107 00000000 5a5a0107 1
1 0107 55550107 55550107 1
0 0ab3 00000000 5a5a0ab3 0
0 0053 00000000 33330053 1
0 0023 00000000 11110023 0
0 0fa3 00000000 5a5a0fa3 0
0 0f13 00000000 5a5a0f13 0
0 0e83 00000000 5a5a0e83 0
0 0053 00000000 33330053 0
0 0105 00000000 44440105 1
0 0107 00000000 55550107 1
